// ==== logic/pe_pkg.sv ====
// processing element package with bitmap widths, typed vectors, command codes and word requests.
package pe_pkg;

        // bitmap geometry.
        localparam int WORD_W = 32;
        localparam int ADDR_W = 9;
        localparam int BIT_INDEX_W = 5;

        // an offset is a word address above a bit index.
        localparam int OFFSET_W = ADDR_W + BIT_INDEX_W;
        localparam int STEP_W = 10;

        // one bitmap word.
        typedef logic [WORD_W-1:0] word_t;

        // word address into the bitmap.
        typedef logic [ADDR_W-1:0] word_addr_t;

        // bit offset, word address in the upper bits.
        typedef logic [OFFSET_W-1:0] offset_t;

        // distance between two marked offsets.
        typedef logic [STEP_W-1:0] step_t;

        // code 3 is unused and never completes.
        typedef enum logic [1:0] {
                CMD_COMPUTE = 2'd0,
                CMD_CLEAR = 2'd1,
                CMD_READ = 2'd2
        } command_e;

        // one word update headed for the bitmap.
        typedef struct packed {
                // request present.
                logic valid;
                // target word.
                word_addr_t addr;
                // bits to OR in, zero for a clear.
                word_t mask;
                // final request of the command.
                logic last;
        } word_request_t;

endpackage

// ==== logic/offset_stepper.sv ====
// offset stepper that walks a strided offset range and gathers its marks into word requests.
`timescale 1ns/1ns

module offset_stepper (
        input logic clock,
        input logic reset_n,
        input logic launch_compute,
        input pe_pkg::offset_t first_offset,
        input pe_pkg::step_t step,
        input pe_pkg::offset_t last_offset,
        input logic update_busy,
        output pe_pkg::word_request_t mark_request
);

        // one spare bit so the sum cannot wrap.
        logic [pe_pkg::OFFSET_W:0] next_offset;
        logic past_last;
        logic leaves_word;
        logic walking;
        pe_pkg::offset_t offset;
        pe_pkg::word_t mask;
        pe_pkg::word_t gathered;

        assign next_offset = (pe_pkg::OFFSET_W + 1)'(offset) + (pe_pkg::OFFSET_W + 1)'(step);
        assign past_last = next_offset > {1'b0, last_offset};

        // word part of the next offset differs from the current one.
        assign leaves_word = next_offset[pe_pkg::OFFSET_W:pe_pkg::BIT_INDEX_W]
                != {1'b0, offset[pe_pkg::OFFSET_W-1:pe_pkg::BIT_INDEX_W]};

        assign gathered = mask | (pe_pkg::word_t'(1) << offset[pe_pkg::BIT_INDEX_W-1:0]);

        // arguments stay stable while start is held.
        always_ff @(posedge clock) begin
                if (!reset_n) begin
                        walking <= 1'b0;
                        mark_request <= '0;
                end else if (launch_compute) begin
                        offset <= first_offset;
                        mask <= '0;
                        if (first_offset > last_offset) begin
                                // empty range, one blank request so done still arrives.
                                mark_request.valid <= 1'b1;
                                mark_request.addr <=
                                        first_offset[pe_pkg::OFFSET_W-1:pe_pkg::BIT_INDEX_W];
                                mark_request.mask <= '0;
                                mark_request.last <= 1'b1;
                                walking <= 1'b0;
                        end else begin
                                mark_request.valid <= 1'b0;
                                walking <= 1'b1;
                        end
                end else if (!update_busy) begin
                        if (walking && (leaves_word || past_last)) begin
                                // word complete, hand it over and start afresh.
                                mark_request.valid <= 1'b1;
                                mark_request.addr <=
                                        offset[pe_pkg::OFFSET_W-1:pe_pkg::BIT_INDEX_W];
                                mark_request.mask <= gathered;
                                mark_request.last <= past_last;
                                mask <= '0;
                                walking <= !past_last;
                        end else begin
                                // any pending request is taken on this edge.
                                mark_request.valid <= 1'b0;
                                if (walking) begin
                                        mask <= gathered;
                                end
                        end
                        if (walking) begin
                                offset <= next_offset[pe_pkg::OFFSET_W-1:0];
                        end
                end
        end

endmodule

// ==== logic/clear_sweeper.sv ====
// clear sweeper that issues a zero-write request for every bitmap word in turn.
`timescale 1ns/1ns

module clear_sweeper #(
        parameter int ADDR_W = pe_pkg::ADDR_W
) (
        input logic clock,
        input logic reset_n,
        input logic launch_clear,
        input logic update_busy,
        output pe_pkg::word_request_t clear_request
);

        logic [ADDR_W-1:0] next_address;

        assign next_address = clear_request.addr + 1'b1;

        always_ff @(posedge clock) begin
                if (!reset_n) begin
                        clear_request <= '0;
                end else if (launch_clear) begin
                        clear_request.valid <= 1'b1;
                        clear_request.addr <= '0;
                        clear_request.mask <= '0;
                        clear_request.last <= 1'b0;
                end else if (clear_request.valid && !update_busy) begin
                        if (clear_request.last) begin
                                // top address written, sweep over.
                                clear_request.valid <= 1'b0;
                        end else begin
                                clear_request.addr <= next_address;
                                clear_request.last <= &next_address;
                        end
                end
        end

endmodule

// ==== logic/bitmap_ram.sv ====
// bitmap storage as a simple dual port RAM with a registered read.
`timescale 1ns/1ns

module bitmap_ram #(
        parameter int ADDR_W = pe_pkg::ADDR_W,
        parameter int WORD_W = pe_pkg::WORD_W
) (
        input logic clock,
        input logic write_enable,
        input pe_pkg::word_addr_t write_address,
        input pe_pkg::word_t write_data,
        input pe_pkg::word_addr_t read_address,
        output pe_pkg::word_t read_data
);

        logic [WORD_W-1:0] memory [2**ADDR_W];

        // read returns the old word on an address collision.
        always_ff @(posedge clock) begin
                if (write_enable) begin
                        memory[write_address] <= write_data;
                end
                read_data <= memory[read_address];
        end

endmodule

// ==== logic/bitmap_update.sv ====
// bitmap updater that turns mark, clear and read commands into RAM traffic and done pulses.
`timescale 1ns/1ns

module bitmap_update #(
        parameter int ADDR_W = pe_pkg::ADDR_W,
        parameter int WORD_W = pe_pkg::WORD_W
) (
        input logic clock,
        input logic reset_n,
        input pe_pkg::word_request_t mark_request,
        input pe_pkg::word_request_t clear_request,
        input logic launch_read,
        input pe_pkg::word_addr_t read_address,
        input logic active,
        output logic update_busy,
        output pe_pkg::word_t read_data,
        output logic command_done
);

        typedef enum logic [1:0] {
                MARK_IDLE,
                MARK_READ_WAIT,
                MARK_WRITE_BACK
        } mark_state_e;

        mark_state_e mark_state;
        logic mark_accept;
        logic clear_accept;
        logic mark_last;
        pe_pkg::word_addr_t mark_address;
        pe_pkg::word_t mark_mask;
        logic ram_we;
        logic write_last;
        pe_pkg::word_addr_t ram_waddr;
        pe_pkg::word_t ram_wdata;
        pe_pkg::word_addr_t ram_raddr;
        pe_pkg::word_t ram_rdata;
        // address capture, RAM read, data capture.
        logic [2:0] read_pipe;
        pe_pkg::word_addr_t read_address_q;

        // requests are dropped once start falls.
        assign mark_accept = (mark_state == MARK_IDLE) && mark_request.valid && active;
        assign clear_accept = (mark_state == MARK_IDLE) && !mark_request.valid
                && clear_request.valid && active;
        assign update_busy = mark_state != MARK_IDLE;

        // the read command owns the read port only in its RAM stage.
        assign ram_raddr = read_pipe[1] ? read_address_q : mark_request.addr;

        always_ff @(posedge clock) begin
                if (!reset_n) begin
                        mark_state <= MARK_IDLE;
                        mark_last <= 1'b0;
                        ram_we <= 1'b0;
                        write_last <= 1'b0;
                        read_pipe <= '0;
                        command_done <= 1'b0;
                        read_data <= '0;
                end else begin
                        case (mark_state)
                                MARK_IDLE: begin
                                        if (mark_accept) begin
                                                mark_last <= mark_request.last;
                                                mark_state <= MARK_READ_WAIT;
                                        end
                                end
                                MARK_READ_WAIT: mark_state <= MARK_WRITE_BACK;
                                default: mark_state <= MARK_IDLE;
                        endcase
                        ram_we <= clear_accept || (mark_state == MARK_READ_WAIT);
                        write_last <= (clear_accept && clear_request.last)
                                || ((mark_state == MARK_READ_WAIT) && mark_last);
                        read_pipe <= {read_pipe[1:0], launch_read};
                        // done rides along with the final write.
                        command_done <= active && ((ram_we && write_last) || read_pipe[2]);
                        if (active && read_pipe[2]) begin
                                read_data <= ram_rdata;
                        end
                end
        end

        always_ff @(posedge clock) begin
                if (mark_accept) begin
                        mark_address <= mark_request.addr;
                        mark_mask <= mark_request.mask;
                end
                if (mark_state == MARK_READ_WAIT) begin
                        // old word is on the read port now.
                        ram_waddr <= mark_address;
                        ram_wdata <= ram_rdata | mark_mask;
                end else if (clear_accept) begin
                        ram_waddr <= clear_request.addr;
                        ram_wdata <= clear_request.mask;
                end
                if (launch_read) begin
                        read_address_q <= read_address;
                end
        end

        bitmap_ram #(
                .ADDR_W(ADDR_W),
                .WORD_W(WORD_W)
        ) bitmap (
                .clock(clock),
                .write_enable(ram_we),
                .write_address(ram_waddr),
                .write_data(ram_wdata),
                .read_address(ram_raddr),
                .read_data(ram_rdata)
        );

endmodule

// ==== logic/processing_element.sv ====
// processing element top level that launches compute, clear and read commands on a bitmap.
`timescale 1ns/1ns

module processing_element #(
        parameter int ADDR_W = pe_pkg::ADDR_W,
        parameter int WORD_W = pe_pkg::WORD_W
) (
        input logic clock,
        input logic reset_n,
        input logic start,
        input pe_pkg::command_e command,
        input pe_pkg::offset_t first_offset,
        input pe_pkg::step_t step,
        input pe_pkg::offset_t last_offset,
        input pe_pkg::word_addr_t read_address,
        output pe_pkg::word_t read_data,
        output logic command_done
);

        logic start_q;
        logic launch;
        logic launch_compute;
        logic launch_clear;
        logic launch_read;
        logic active;
        logic update_busy;
        pe_pkg::word_request_t mark_request;
        pe_pkg::word_request_t clear_request;

        always_ff @(posedge clock) begin
                if (!reset_n) begin
                        start_q <= 1'b0;
                end else begin
                        start_q <= start;
                end
        end

        // high only in the first cycle of start.
        assign launch = start && !start_q;
        assign launch_compute = launch && (command == pe_pkg::CMD_COMPUTE);
        assign launch_clear = launch && (command == pe_pkg::CMD_CLEAR);
        assign launch_read = launch && (command == pe_pkg::CMD_READ);
        assign active = start;

        offset_stepper stepper (
                .clock(clock),
                .reset_n(reset_n),
                .launch_compute(launch_compute),
                .first_offset(first_offset),
                .step(step),
                .last_offset(last_offset),
                .update_busy(update_busy),
                .mark_request(mark_request)
        );

        clear_sweeper #(
                .ADDR_W(ADDR_W)
        ) sweeper (
                .clock(clock),
                .reset_n(reset_n),
                .launch_clear(launch_clear),
                .update_busy(update_busy),
                .clear_request(clear_request)
        );

        bitmap_update #(
                .ADDR_W(ADDR_W),
                .WORD_W(WORD_W)
        ) updater (
                .clock(clock),
                .reset_n(reset_n),
                .mark_request(mark_request),
                .clear_request(clear_request),
                .launch_read(launch_read),
                .read_address(read_address),
                .active(active),
                .update_busy(update_busy),
                .read_data(read_data),
                .command_done(command_done)
        );

endmodule

// ==== verification/pe_checker.sv ====
// protocol checker for the processing element done pulse and read data.
`timescale 1ns/1ns

module pe_checker (
        input logic clock,
        input logic reset_n,
        input logic start,
        input logic command_done,
        input pe_pkg::word_t read_data
);

        // done is a single cycle pulse.
        done_single_cycle: assert property (
                @(posedge clock) disable iff (!reset_n)
                command_done |=> !command_done
        ) else $error("command_done held high for more than one cycle");

        done_while_started: assert property (
                @(posedge clock) disable iff (!reset_n)
                command_done |-> start
        ) else $error("command_done raised while start was low");

        // read data only moves with a read's done.
        read_data_on_done: assert property (
                @(posedge clock) disable iff (!reset_n)
                $changed(read_data) |-> command_done
        ) else $error("read_data changed outside a done cycle");

endmodule

bind processing_element pe_checker checks (
        .clock(clock),
        .reset_n(reset_n),
        .start(start),
        .command_done(command_done),
        .read_data(read_data)
);

// ==== verification/processing_element_tb.sv ====
// testbench for the bitmap processing element, driven from a command table against a bitmap model.
`timescale 1ns/1ns

module processing_element_tb;

        localparam int CLOCK_PERIOD = 10;
        localparam int RESET_CYCLES = 8;
        localparam int WORDS = 2 ** pe_pkg::ADDR_W;
        localparam int MAX_OFFSET = 2 ** pe_pkg::OFFSET_W - 1;
        // one write per word plus pipeline slack.
        localparam int CLEAR_CYCLES = WORDS + 8;
        localparam int COMMAND_CYCLES = 4 * CLEAR_CYCLES;
        localparam int RANDOM_ROWS = 6;
        localparam int READ_EDGES = 3;

        typedef struct packed {
                pe_pkg::command_e command;
                pe_pkg::offset_t first_offset;
                pe_pkg::step_t step;
                pe_pkg::offset_t last_offset;
                pe_pkg::word_addr_t read_address;
        } test_row_t;

        logic clock;
        logic reset_n;
        logic start;
        pe_pkg::command_e command;
        pe_pkg::offset_t first_offset;
        pe_pkg::step_t step;
        pe_pkg::offset_t last_offset;
        pe_pkg::word_addr_t read_address;
        pe_pkg::word_t read_data;
        logic command_done;

        pe_pkg::word_t model [WORDS];
        test_row_t rows [$];
        logic [31:0] lfsr_state;
        int error_count;
        int check_count;
        longint run_limit;

        processing_element #(
                .ADDR_W(pe_pkg::ADDR_W),
                .WORD_W(pe_pkg::WORD_W)
        ) UUT (
                .clock(clock),
                .reset_n(reset_n),
                .start(start),
                .command(command),
                .first_offset(first_offset),
                .step(step),
                .last_offset(last_offset),
                .read_address(read_address),
                .read_data(read_data),
                .command_done(command_done)
        );

        initial clock = 1'b0;
        always #(CLOCK_PERIOD / 2) clock = ~clock;

        function automatic test_row_t make_row(input pe_pkg::command_e cmd, input int first,
                        input int stride, input int last, input int addr);
                test_row_t row;
                row.command = cmd;
                row.first_offset = pe_pkg::offset_t'(first);
                row.step = pe_pkg::step_t'(stride);
                row.last_offset = pe_pkg::offset_t'(last);
                row.read_address = pe_pkg::word_addr_t'(addr);
                return row;
        endfunction

        // galois lfsr stepped once for each bit taken.
        function automatic logic [31:0] draw_bits(input int count);
                logic [31:0] value;
                int i;
                value = '0;
                for (i = 0; i < count; i++) begin
                        value = {value[30:0], lfsr_state[0]};
                        lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003
                                : lfsr_state >> 1;
                end
                return value;
        endfunction

        task automatic apply_model(input test_row_t row);
                int offset;
                if (row.command == pe_pkg::CMD_COMPUTE) begin
                        offset = int'(row.first_offset);
                        while (offset <= int'(row.last_offset)) begin
                                model[pe_pkg::word_addr_t'(offset >> 5)] |=
                                        pe_pkg::word_t'(1) << (offset & 31);
                                offset += int'(row.step);
                        end
                end else if (row.command == pe_pkg::CMD_CLEAR) begin
                        foreach (model[w]) model[w] = '0;
                end
        endtask

        task automatic check_word(input pe_pkg::word_addr_t addr, input pe_pkg::word_t actual,
                        input pe_pkg::word_t expected);
                check_count++;
                if (actual !== expected) begin
                        error_count++;
                        $display("[FAIL] read_data at word %h: got %h, expected %h",
                                addr, actual, expected);
                end
        endtask

        task automatic check_done(input logic seen, input string what);
                check_count++;
                if (!seen) begin
                        error_count++;
                        $display("no command_done for %s within %0d cycles", what, COMMAND_CYCLES);
                end
        endtask

        // the first counted edge is the one that samples start.
        task automatic check_latency(input int edges);
                int expected;
                expected = READ_EDGES + 1;
                check_count++;
                if (edges != expected) begin
                        error_count++;
                        $display("[FAIL] command_done latency: got %h edges, expected %h",
                                edges, expected);
                end
        endtask

        // start stays high through the done cycle and then drops for one cycle.
        task automatic run_command(input test_row_t row, output int edges, output logic seen);
                command = row.command;
                first_offset = row.first_offset;
                step = row.step;
                last_offset = row.last_offset;
                read_address = row.read_address;
                start = 1'b1;
                edges = 0;
                seen = 1'b0;
                while (!seen && edges < COMMAND_CYCLES) begin
                        @(negedge clock);
                        edges++;
                        seen = command_done;
                end
                @(negedge clock);
                start = 1'b0;
                @(negedge clock);
        endtask

        task automatic read_and_check(input pe_pkg::word_addr_t addr);
                int edges;
                logic seen;
                run_command(make_row(pe_pkg::CMD_READ, 0, 0, 0, int'(addr)), edges, seen);
                check_done(seen, "read");
                if (seen) check_latency(edges);
                check_word(addr, read_data, model[addr]);
        endtask

        task automatic build_table();
                int i;
                int first;
                int stride;
                int last;
                logic [31:0] bits;
                rows.push_back(make_row(pe_pkg::CMD_CLEAR, 0, 0, 0, 0));
                rows.push_back(make_row(pe_pkg::CMD_READ, 0, 0, 0, 0));
                rows.push_back(make_row(pe_pkg::CMD_READ, 0, 0, 0, 1));
                rows.push_back(make_row(pe_pkg::CMD_READ, 0, 0, 0, 255));
                rows.push_back(make_row(pe_pkg::CMD_READ, 0, 0, 0, 511));
                rows.push_back(make_row(pe_pkg::CMD_COMPUTE, 5, 1, 40, 0));
                rows.push_back(make_row(pe_pkg::CMD_COMPUTE, 3, 100, 2000, 0));
                // two overlapping walks accumulate.
                rows.push_back(make_row(pe_pkg::CMD_COMPUTE, 10, 7, 300, 0));
                rows.push_back(make_row(pe_pkg::CMD_COMPUTE, 0, 3, 200, 0));
                // empty range that only raises done.
                rows.push_back(make_row(pe_pkg::CMD_COMPUTE, 500, 4, 100, 0));
                rows.push_back(make_row(pe_pkg::CMD_CLEAR, 0, 0, 0, 0));
                rows.push_back(make_row(pe_pkg::CMD_READ, 0, 0, 0, 0));
                rows.push_back(make_row(pe_pkg::CMD_READ, 0, 0, 0, 3));
                rows.push_back(make_row(pe_pkg::CMD_READ, 0, 0, 0, 62));
                rows.push_back(make_row(pe_pkg::CMD_READ, 0, 0, 0, 511));
                lfsr_state = 32'hfd58_7f6c;
                for (i = 0; i < RANDOM_ROWS; i++) begin
                        bits = draw_bits(pe_pkg::OFFSET_W);
                        first = int'(bits);
                        bits = draw_bits(pe_pkg::STEP_W);
                        stride = (bits == 0) ? 1 : int'(bits);
                        bits = draw_bits(10);
                        last = first + int'(bits);
                        if (last > MAX_OFFSET) last = MAX_OFFSET;
                        rows.push_back(make_row(pe_pkg::CMD_COMPUTE, first, stride, last, 0));
                end
        endtask

        initial begin
                int edges;
                int word;
                logic seen;
                reset_n = 1'b0;
                start = 1'b0;
                command = pe_pkg::CMD_COMPUTE;
                first_offset = '0;
                step = '0;
                last_offset = '0;
                read_address = '0;
                error_count = 0;
                check_count = 0;
                run_limit = 0;
                foreach (model[w]) model[w] = '0;
                build_table();
                run_limit = longint'(rows.size()) * 2 * COMMAND_CYCLES * CLOCK_PERIOD;
                repeat (RESET_CYCLES) @(negedge clock);
                reset_n = 1'b1;
                @(negedge clock);
                foreach (rows[i]) begin
                        if (rows[i].command == pe_pkg::CMD_READ) begin
                                read_and_check(rows[i].read_address);
                        end else begin
                                run_command(rows[i], edges, seen);
                                check_done(seen, rows[i].command.name());
                                apply_model(rows[i]);
                                // every word the walk could touch.
                                if (rows[i].command == pe_pkg::CMD_COMPUTE) begin
                                        for (word = int'(rows[i].first_offset) >> 5;
                                                        word <= int'(rows[i].last_offset) >> 5;
                                                        word++) begin
                                                read_and_check(pe_pkg::word_addr_t'(word));
                                        end
                                end
                        end
                end
                $display("checks %0d, errors %0d", check_count, error_count);
                if (error_count == 0) begin
                        $display("Test passed");
                end else begin
                        $display("Test failed");
                end
                $finish;
        end

        initial begin
                wait (run_limit > 0);
                #(run_limit);
                $display("watchdog expired after %0d ns with the table unfinished", run_limit);
                $display("Test failed");
                $finish;
        end

endmodule

// ==== build.f ====
logic/pe_pkg.sv
logic/offset_stepper.sv
logic/clear_sweeper.sv
logic/bitmap_ram.sv
logic/bitmap_update.sv
logic/processing_element.sv
verification/pe_checker.sv
verification/processing_element_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP := processing_element_tb
RTL_TOP := processing_element
FILELIST := build.f
FLAGS := --binary --assert --timing
LINT_FLAGS := --lint-only -Wall --timing
BUILD_DIR := obj_dir
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Test passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
